/* Bender.yml */
package:
  name: read_master

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/read_master_pkg.sv
      - hdl/descriptor_regs.sv
      - hdl/read_request_gen.sv
      - hdl/packet_framer.sv
      - hdl/stream_fifo.sv
      - hdl/read_master.sv
      - testbench/tb_read_master.sv

/* flist.f */
+incdir+hdl
hdl/read_master_pkg.sv
hdl/descriptor_regs.sv
hdl/read_request_gen.sv
hdl/packet_framer.sv
hdl/stream_fifo.sv
hdl/read_master.sv
testbench/tb_read_master.sv

/* hdl/descriptor_regs.sv */
`include "read_master_params.svh"

module descriptor_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  read_master_pkg::read_cmd_t        cmd,            // descriptor from the dispatcher
  input  logic                              cmd_valid,
  output logic                              cmd_ready,
  output read_master_pkg::read_resp_t       resp,
  output logic                              resp_valid,
  input  logic                              resp_ready,
  input  logic                              idle,           // all reads posted and returned
  input  logic                              posted_all,     // length counter is zero
  output logic                              go,             // descriptor accepted this cycle
  output logic [`RM_ADDR_WIDTH-1:0]         start_address,  // only meaningful while go is high
  output logic [`RM_LENGTH_WIDTH-1:0]       length,         // only meaningful while go is high
  output logic [`RM_CHANNEL_WIDTH-1:0]      channel,
  output logic [`RM_ERROR_WIDTH-1:0]        error,
  output logic                              generate_sop,
  output logic                              generate_eop
);
  import read_master_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        idle_d1;     // previous idle so the rising edge can be found
  logic        idle_rise;   // the last outstanding read just came back
  logic        resp_pop;

  assign go            = cmd_valid & cmd_ready;
  assign start_address = cmd.address;   // the counters load these at go
  assign length        = cmd.length;
  assign idle_rise     = idle & ~idle_d1;
  assign resp_pop      = resp_valid & resp_ready;
  assign cmd_ready     = (state == CTRL_IDLE);     // drops the cycle after go
  assign resp_valid    = (state == CTRL_RESPOND);  // stays up while the sink stalls

  always_comb
  begin
    state_next = state;
    case (state)
      CTRL_IDLE:    if (go) state_next = CTRL_BUSY;
      CTRL_BUSY:    if (idle_rise) state_next = CTRL_RESPOND;  // idle fell the cycle after go
      CTRL_RESPOND: if (resp_pop) state_next = CTRL_IDLE;
      default:      state_next = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state   <= CTRL_IDLE;
      idle_d1 <= 1'b1;  // the request generator comes out of reset idle
    end
    else
    begin
      state   <= state_next;
      idle_d1 <= idle;
    end
  end

  always_ff @(posedge clk)
  begin
    if (go)
    begin
      channel      <= cmd.channel;       // held for the framer until the next descriptor
      error        <= cmd.error;
      generate_sop <= cmd.generate_sop;
      generate_eop <= cmd.generate_eop;
    end
    if ((state == CTRL_BUSY) && idle_rise)
    begin
      resp.done         <= posted_all;  // sampled once so the response is stable while held
      resp.all_returned <= idle;
    end
  end

endmodule

/* hdl/packet_framer.sv */
`include "read_master_params.svh"

module packet_framer (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            go,
  input  logic [`RM_LENGTH_WIDTH-1:0]     length,        // descriptor length, valid at go
  input  logic                            generate_sop,
  input  logic                            generate_eop,
  input  logic [`RM_CHANNEL_WIDTH-1:0]    channel,
  input  logic [`RM_ERROR_WIDTH-1:0]      error,
  input  logic [`RM_DATA_WIDTH-1:0]       readdata,
  input  logic                            readdatavalid,
  output logic                            fifo_write,
  output read_master_pkg::st_beat_t       fifo_beat
);
  localparam int WORDS_WIDTH = `RM_LENGTH_WIDTH - `RM_BYTES_LOG2 + 1;  // room for the round up

  logic [`RM_BYTES_LOG2-1:0]  length_rem;    // bytes used in a partial last word
  logic [WORDS_WIDTH-1:0]     word_count;    // length rounded up to whole words
  logic [WORDS_WIDTH-1:0]     words_left;    // words still expected from memory
  logic [`RM_EMPTY_WIDTH-1:0] last_empty;    // empty value for the eop beat
  logic                       first_word;
  logic                       last_word;
  logic                       mark_eop;
  logic [`RM_DATA_WIDTH-1:0]  swapped_data;  // readdata in network byte order

  assign length_rem = length[`RM_BYTES_LOG2-1:0];
  assign word_count = WORDS_WIDTH'(length[`RM_LENGTH_WIDTH-1:`RM_BYTES_LOG2])
                    + WORDS_WIDTH'(length_rem != '0);
  assign last_word  = (words_left == WORDS_WIDTH'(1));
  assign mark_eop   = last_word & generate_eop;

  // byte lane zero of memory becomes the most significant symbol of the stream
  always_comb
  begin
    for (int i = 0; i < `RM_BYTES; i++)
      swapped_data[i*`RM_SYMBOL_WIDTH +: `RM_SYMBOL_WIDTH] =
        readdata[(`RM_BYTES-1-i)*`RM_SYMBOL_WIDTH +: `RM_SYMBOL_WIDTH];
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      words_left <= '0;
      first_word <= 1'b0;
      fifo_write <= 1'b0;
    end
    else
    begin
      fifo_write <= readdatavalid;  // each returned word lands in the FIFO one cycle later
      if (go)
      begin
        words_left <= word_count;
        first_word <= 1'b1;
      end
      else if (readdatavalid)
      begin
        words_left <= words_left - 1'b1;
        first_word <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (go)
      last_empty <= (length_rem == '0) ? '0 : `RM_EMPTY_WIDTH'(`RM_BYTES - length_rem);
    if (readdatavalid)
    begin
      fifo_beat.data    <= swapped_data;
      fifo_beat.sop     <= first_word & generate_sop;
      fifo_beat.eop     <= mark_eop;
      fifo_beat.empty   <= mark_eop ? last_empty : '0;  // empty only means something with eop
      fifo_beat.channel <= channel;
      fifo_beat.error   <= error;
    end
  end

endmodule

/* hdl/read_master.sv */
`include "read_master_params.svh"

module read_master (
  input  logic                          clk,
  input  logic                          reset,
  input  read_master_pkg::read_cmd_t    cmd,            // descriptor sink
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  output read_master_pkg::read_resp_t   resp,           // response source
  output logic                          resp_valid,
  input  logic                          resp_ready,
  output read_master_pkg::mm_req_t      mm,             // memory read port
  input  logic                          waitrequest,
  input  logic [`RM_DATA_WIDTH-1:0]     readdata,
  input  logic                          readdatavalid,
  output read_master_pkg::st_beat_t     src,            // stream source
  output logic                          src_valid,
  input  logic                          src_ready
);
  import read_master_pkg::*;

  logic                         go;
  logic [`RM_ADDR_WIDTH-1:0]    start_address;
  logic [`RM_LENGTH_WIDTH-1:0]  length;
  logic [`RM_CHANNEL_WIDTH-1:0] channel;
  logic [`RM_ERROR_WIDTH-1:0]   error;
  logic                         generate_sop;
  logic                         generate_eop;
  logic                         posted_all;
  logic                         idle;
  logic                         fifo_write;
  st_beat_t                     fifo_beat;
  logic [`RM_FIFO_DEPTH_LOG2:0] fifo_used;  // feeds the read throttle

  descriptor_regs descriptor_regs_inst (
    .clk, .reset, .cmd, .cmd_valid, .cmd_ready, .resp, .resp_valid, .resp_ready,
    .idle, .posted_all, .go, .start_address, .length, .channel, .error,
    .generate_sop, .generate_eop
  );

  read_request_gen read_request_gen_inst (
    .clk, .reset, .go, .start_address, .length, .fifo_used, .readdatavalid,
    .waitrequest, .mm, .posted_all, .idle
  );

  packet_framer packet_framer_inst (
    .clk, .reset, .go, .length, .generate_sop, .generate_eop, .channel, .error,
    .readdata, .readdatavalid, .fifo_write, .fifo_beat
  );

  stream_fifo stream_fifo_inst (
    .clk        (clk),
    .reset      (reset),
    .write      (fifo_write),
    .write_beat (fifo_beat),
    .read       (src_valid & src_ready),  // a beat leaves when the sink takes it
    .head       (src),
    .not_empty  (src_valid),
    .used       (fifo_used)
  );

endmodule

/* hdl/read_master_params.svh */
`ifndef READ_MASTER_PARAMS_SVH
`define READ_MASTER_PARAMS_SVH

// memory side word and its byte lanes
`define RM_DATA_WIDTH 32          // one memory word and one stream beat
`define RM_BYTES 4                // bytes carried by each word
`define RM_BYTES_LOG2 2           // byte offset bits inside a word
`define RM_EMPTY_WIDTH 2          // unused symbol count on the last beat

// descriptor field widths
`define RM_ADDR_WIDTH 32          // byte address of the memory port
`define RM_LENGTH_WIDTH 32        // transfer length in bytes
`define RM_CHANNEL_WIDTH 8        // stream channel tag
`define RM_ERROR_WIDTH 8          // stream error tag

// stream buffer sizing
`define RM_FIFO_DEPTH 16          // entries in the stream FIFO
`define RM_FIFO_DEPTH_LOG2 4      // pointer width of the stream FIFO

// stream symbol size, the byte swap works on these
`define RM_SYMBOL_WIDTH 8

`endif

/* hdl/read_master_pkg.sv */
`include "read_master_params.svh"

package read_master_pkg;

  // descriptor handed over by the dispatcher, one per buffer
  typedef struct packed {
    logic [`RM_ADDR_WIDTH-1:0]    address;       // must be word aligned
    logic [`RM_LENGTH_WIDTH-1:0]  length;        // bytes to read, last word may be partial
    logic [`RM_CHANNEL_WIDTH-1:0] channel;       // copied onto every beat
    logic [`RM_ERROR_WIDTH-1:0]   error;         // copied onto every beat
    logic                         generate_sop;  // mark the first beat as start of packet
    logic                         generate_eop;  // mark the last beat as end of packet
  } read_cmd_t;

  // status returned once the descriptor has been fully read
  typedef struct packed {
    logic done;          // the length counter reached zero so every read was posted
    logic all_returned;  // and every posted read came back
  } read_resp_t;

  // single word read request towards memory
  typedef struct packed {
    logic [`RM_ADDR_WIDTH-1:0] address;  // word aligned byte address
    logic                      read;     // held until waitrequest drops
  } mm_req_t;

  // one beat of the outgoing stream, also the FIFO entry format
  typedef struct packed {
    logic [`RM_DATA_WIDTH-1:0]    data;     // already in network byte order
    logic                         sop;
    logic                         eop;
    logic [`RM_EMPTY_WIDTH-1:0]   empty;    // only nonzero on an eop beat
    logic [`RM_CHANNEL_WIDTH-1:0] channel;
    logic [`RM_ERROR_WIDTH-1:0]   error;
  } st_beat_t;

  // descriptor handshake control
  typedef enum logic [1:0] {
    CTRL_IDLE,     // waiting for a descriptor
    CTRL_BUSY,     // reads are being posted or are still returning
    CTRL_RESPOND   // response presented until the sink pops it
  } ctrl_state_t;

endpackage

/* hdl/read_request_gen.sv */
`include "read_master_params.svh"

module read_request_gen (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            go,
  input  logic [`RM_ADDR_WIDTH-1:0]       start_address,
  input  logic [`RM_LENGTH_WIDTH-1:0]     length,
  input  logic [`RM_FIFO_DEPTH_LOG2:0]    fifo_used,      // fill count of the stream FIFO
  input  logic                            readdatavalid,
  input  logic                            waitrequest,
  output read_master_pkg::mm_req_t        mm,
  output logic                            posted_all,     // every read of the descriptor issued
  output logic                            idle            // and every one of them returned
);
  localparam int COUNT_WIDTH = `RM_FIFO_DEPTH_LOG2 + 2;  // fill count plus pending without wrap

  logic [`RM_ADDR_WIDTH-1:0]    address_counter;
  logic [`RM_LENGTH_WIDTH-1:0]  length_counter;    // bytes still to be requested
  logic [`RM_FIFO_DEPTH_LOG2:0] pending_reads;     // issued reads whose data has not returned
  logic                         read_reg;          // registered read strobe
  logic                         return_d1;         // word sitting in the framer register
  logic                         read_issued;
  logic [COUNT_WIDTH-1:0]       occupancy;         // FIFO slots already spoken for
  logic                         too_many_pending;

  assign read_issued = mm.read & ~waitrequest;
  assign posted_all  = (length_counter == '0);
  assign idle        = posted_all & (pending_reads == '0);
  // the framer stage holds one word that is neither pending nor in the FIFO yet
  assign occupancy = COUNT_WIDTH'(fifo_used) + COUNT_WIDTH'(pending_reads)
                   + COUNT_WIDTH'(return_d1);
  // the strobe is registered so one more read can slip out after this rises
  assign too_many_pending = occupancy > COUNT_WIDTH'(`RM_FIFO_DEPTH - 2);
  assign mm.address = address_counter;
  assign mm.read    = read_reg & ~posted_all;  // no extra read once the length runs out

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      address_counter <= '0;
      length_counter  <= '0;
    end
    else if (go)
    begin
      address_counter <= start_address;
      length_counter  <= length;
    end
    else if (read_issued)
    begin
      address_counter <= address_counter + `RM_ADDR_WIDTH'(`RM_BYTES);  // one word per read
      if (length_counter < `RM_LENGTH_WIDTH'(`RM_BYTES))
        length_counter <= '0;  // partial last word still costs a whole read
      else
        length_counter <= length_counter - `RM_LENGTH_WIDTH'(`RM_BYTES);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pending_reads <= '0;
    else
    begin
      case ({read_issued, readdatavalid})
        2'b10:   pending_reads <= pending_reads + 1'b1;
        2'b01:   pending_reads <= pending_reads - 1'b1;
        default: pending_reads <= pending_reads;  // both or neither leaves the count alone
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      read_reg  <= 1'b0;
      return_d1 <= 1'b0;
    end
    else
    begin
      return_d1 <= readdatavalid;  // mirrors the write strobe of the framer
      if (!posted_all && !too_many_pending)
        read_reg <= 1'b1;
      else if (posted_all || (read_issued && too_many_pending))
        read_reg <= 1'b0;  // a read waiting on waitrequest is never withdrawn
    end
  end

endmodule

/* hdl/stream_fifo.sv */
`include "read_master_params.svh"

module stream_fifo #(
  parameter int RM_DEPTH_LOG2 = `RM_FIFO_DEPTH_LOG2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        write,
  input  read_master_pkg::st_beat_t   write_beat,
  input  logic                        read,        // pops the head entry
  output read_master_pkg::st_beat_t   head,        // show-ahead view of the oldest entry
  output logic                        not_empty,
  output logic [RM_DEPTH_LOG2:0]      used         // one extra bit so a full FIFO reads as depth
);
  import read_master_pkg::*;

  localparam int DEPTH = 1 << RM_DEPTH_LOG2;

  st_beat_t                 mem [DEPTH];
  logic [RM_DEPTH_LOG2-1:0] wr_ptr;      // wraps on its own since the depth is a power of two
  logic [RM_DEPTH_LOG2-1:0] rd_ptr;
  logic [RM_DEPTH_LOG2:0]   count;
  logic                     do_read;     // a pop on an empty FIFO is ignored

  assign do_read   = read & not_empty;
  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign used      = count;

  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_beat;  // the read request throttle keeps this from overrunning
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;
      case ({write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* testbench/tb_read_master.sv */
`include "read_master_params.svh"

module tb_read_master;
  timeunit 1ns;
  timeprecision 100ps;
  import read_master_pkg::*;

  typedef struct packed {
    read_cmd_t cmd;    // descriptor handed to the DUT
    logic      stall;  // hold the stream sink off for a long stretch
  } test_vec_t;

  localparam int NUM_VECTORS = 8;
  localparam logic [31:0] MEM_XOR = 32'hC3A5_5A3C;  // keeps the four bytes of a word distinct

  logic clk = 1'b0;
  logic reset = 1'b1;
  read_cmd_t cmd = '0;
  logic cmd_valid = 1'b0;
  logic cmd_ready;
  read_resp_t resp;
  logic resp_valid;
  logic resp_ready = 1'b0;
  mm_req_t mm;
  logic waitrequest = 1'b0;
  logic [`RM_DATA_WIDTH-1:0] readdata = '0;
  logic readdatavalid = 1'b0;
  st_beat_t src;
  logic src_valid;
  logic src_ready = 1'b0;

  test_vec_t vectors [NUM_VECTORS];
  logic [31:0] addr_q [$];  // reads issued but not yet returned
  st_beat_t beat_q [$];     // beats taken by the stream sink
  integer seed = 4;
  logic sink_hold = 1'b0;
  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  bit timed_out = 1'b0;

  read_master read_master_inst (.*);

  always #4 clk = ~clk;  // 8 ns period

  // memory read model and stream sink share one process so the random sequence is fixed
  always @(posedge clk)
  begin
    logic hold;
    hold = sink_hold;  // sampled at the edge since the test only changes it after the edge
    if (reset)
      addr_q.delete();
    else
    begin
      if (mm.read && !waitrequest)
        addr_q.push_back(mm.address);  // a read is issued when waitrequest is low
      if (src_valid && src_ready)
        beat_q.push_back(src);
    end
    #1;
    waitrequest = ($unsigned($random(seed)) % 4) == 0;
    src_ready = hold ? 1'b0 : (($unsigned($random(seed)) % 4) != 0);
    if (addr_q.size() > 0 && ($unsigned($random(seed)) % 3) != 0)
    begin
      readdata = mem_word(addr_q.pop_front());  // data comes back in order with random gaps
      readdatavalid = 1'b1;
    end
    else
      readdatavalid = 1'b0;
  end

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return (addr >> 2) ^ MEM_XOR;  // word address mixed with a constant
  endfunction

  function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};  // memory lane 0 goes out first
  endfunction

  function automatic test_vec_t make_vec(input logic [31:0] addr, input logic [31:0] len,
                                         input logic [7:0] ch, input logic [7:0] err,
                                         input logic sop, input logic eop, input logic stall);
    test_vec_t v;
    v.cmd = '{address: addr, length: len, channel: ch, error: err,
              generate_sop: sop, generate_eop: eop};
    v.stall = stall;
    return v;
  endfunction

  function automatic st_beat_t expected_beat(input test_vec_t v, input int idx, input int nbeats);
    st_beat_t b;
    int rem;
    rem = v.cmd.length % 4;
    b.data = reverse_bytes(mem_word(v.cmd.address + 32'(4 * idx)));
    b.sop = v.cmd.generate_sop && (idx == 0);
    b.eop = v.cmd.generate_eop && (idx == nbeats - 1);
    b.empty = (b.eop && rem != 0) ? `RM_EMPTY_WIDTH'(4 - rem) : '0;  // unused bytes of the tail
    b.channel = v.cmd.channel;
    b.error = v.cmd.error;
    return b;
  endfunction

  task automatic compare_beat(input string name, input st_beat_t exp, input st_beat_t act);
    if (act !== exp)
    begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_resp(input string name, input read_resp_t exp, input read_resp_t act);
    if (act !== exp)
    begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("%s: timeout, %s", name, what);
    timed_out = 1'b1;
    fail_count++;
  endtask

  task automatic run_descriptor(input int idx);
    test_vec_t v;
    string name;
    int nbeats;
    int errors_before;
    int n;
    bit seen;
    read_resp_t exp_resp;
    v = vectors[idx];
    name = $sformatf("desc%0d", idx);
    nbeats = (v.cmd.length + 3) / 4;  // a partial last word still takes a whole beat
    errors_before = error_count;
    exp_resp.done = 1'b1;
    exp_resp.all_returned = 1'b1;
    beat_q.delete();
    @(posedge clk);
    #1;
    sink_hold = v.stall;
    cmd = v.cmd;
    cmd_valid = 1'b1;
    seen = 1'b0;
    for (n = 0; n < 50 && !seen; n++)
    begin
      @(posedge clk);
      seen = cmd_ready;  // accepted at this edge
    end
    if (!seen)
    begin
      report_timeout(name, "the command was never accepted");
      return;
    end
    #1 cmd_valid = 1'b0;
    if (v.stall)
    begin
      repeat (100) @(posedge clk);  // long back-pressure while reads keep going out
      #1 sink_hold = 1'b0;
    end
    seen = 1'b0;
    for (n = 0; n < 3000 && !seen; n++)
    begin
      @(posedge clk);
      seen = resp_valid;
    end
    if (!seen)
    begin
      report_timeout(name, "no response arrived");
      return;
    end
    repeat (6)  // while the response is held no new command may be taken
    begin
      @(posedge clk);
      compare_bit({name, " cmd_ready while held"}, 1'b0, cmd_ready);
      compare_bit({name, " resp_valid while held"}, 1'b1, resp_valid);
    end
    compare_resp({name, " response"}, exp_resp, resp);
    #1 resp_ready = 1'b1;
    @(posedge clk);  // resp_valid is high so the response pops here
    #1 resp_ready = 1'b0;
    @(posedge clk);
    compare_bit({name, " single response"}, 1'b0, resp_valid);
    compare_bit({name, " cmd_ready after pop"}, 1'b1, cmd_ready);
    for (n = 0; n < 2000 && beat_q.size() < nbeats; n++)
      @(posedge clk);
    if (beat_q.size() < nbeats)
    begin
      report_timeout(name, $sformatf("only %0d of %0d beats arrived", beat_q.size(), nbeats));
      return;
    end
    repeat (20) @(posedge clk);  // give any duplicated beat time to show up
    if (beat_q.size() != nbeats)
    begin
      $display("Mismatch %s beat count: expected %0d, actual %0d", name, nbeats, beat_q.size());
      error_count++;
    end
    for (n = 0; n < nbeats; n++)
      compare_beat($sformatf("%s beat %0d", name, n), expected_beat(v, n, nbeats), beat_q[n]);
    if (error_count == errors_before)
      pass_count++;
    else
      fail_count++;
    $display("%s: %s, %0d beats", name, (error_count == errors_before) ? "ok" : "FAILED", nbeats);
  endtask

  initial
  begin
    int errors_before;
    vectors[0] = make_vec(32'h0000_1000, 4, 8'h01, 8'h00, 1'b1, 1'b1, 1'b0);
    vectors[1] = make_vec(32'h0000_2000, 7, 8'h02, 8'h03, 1'b1, 1'b1, 1'b0);
    vectors[2] = make_vec(32'h0000_3010, 13, 8'h07, 8'h00, 1'b1, 1'b1, 1'b0);
    vectors[3] = make_vec(32'h0000_4000, 64, 8'h55, 8'h0a, 1'b1, 1'b1, 1'b0);
    vectors[4] = make_vec(32'h0000_5004, 22, 8'h09, 8'h01, 1'b0, 1'b1, 1'b0);
    vectors[5] = make_vec(32'h0000_6000, 10, 8'h03, 8'h02, 1'b1, 1'b0, 1'b0);
    vectors[6] = make_vec(32'h0000_7000, 160, 8'h12, 8'h00, 1'b1, 1'b1, 1'b1);  // 40 words
    vectors[7] = make_vec(32'h0000_8008, 8, 8'hf0, 8'h0f, 1'b0, 1'b0, 1'b0);
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    @(posedge clk);
    errors_before = error_count;
    compare_bit("reset cmd_ready", 1'b1, cmd_ready);
    compare_bit("reset resp_valid", 1'b0, resp_valid);
    compare_bit("reset src_valid", 1'b0, src_valid);
    compare_bit("reset mm.read", 1'b0, mm.read);
    if (error_count == errors_before)
      pass_count++;
    else
      fail_count++;
    $display("reset: %s", (error_count == errors_before) ? "ok" : "FAILED");
    for (int i = 0; i < NUM_VECTORS && !timed_out; i++)
      run_descriptor(i);
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0 && !timed_out)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
